// File: build.f
+incdir+sim
hdl/isaPkg.sv
hdl/frontendPkg.sv
hdl/laneIfs.sv
hdl/fetchGroupSplitter.sv
hdl/laneDecoder.sv
hdl/groupRetirer.sv
hdl/decodeFrontend.sv
sim/tbDecodeFrontend.sv

// File: hdl/decodeFrontend.sv
`timescale 1ns/1ps
`default_nettype none

module decodeFrontend import isaPkg::*, frontendPkg::*; (
    input  logic                                   clk,
    input  logic                                   arstN,
    input  logic                                   fetchValid,
    input  logic [FetchWidth-1:0]                  fetchWord,
    input  logic                                   isUserRequest,
    input  logic                                   wdInterruption,
    output logic                                   groupValid,
    output logic [CountWidth-1:0]                  opCount,
    output logic [LaneCount*IdWidth-1:0]           opIds,
    output logic [LaneCount*RegWidth-1:0]          opRegD,
    output logic [LaneCount*RegWidth-1:0]          opRegA,
    output logic [LaneCount*RegWidth-1:0]          opRegB,
    output logic [LaneCount*OffsetWidth-1:0]       opOffsets,
    output logic [LaneCount*BranchCondWidth-1:0]   opBranchConds,
    output logic                                   illegalOp,
    output logic                                   halted
);

    laneInIf  laneIn  [LaneCount] ();
    laneOutIf laneOut [LaneCount] ();

    fetchGroupSplitter i_splitter (
        .clk            (clk),
        .arstN          (arstN),
        .fetchValid     (fetchValid),
        .fetchWord      (fetchWord),
        .isUserRequest  (isUserRequest),
        .wdInterruption (wdInterruption),
        .lanes          (laneIn)
    );

    for (genvar i = 0; i < LaneCount; i++) begin : gDecode
        laneDecoder i_decoder (
            .clk     (clk),
            .arstN   (arstN),
            .laneIn  (laneIn[i]),
            .laneOut (laneOut[i])
        );
    end

    groupRetirer i_retirer (
        .clk           (clk),
        .arstN         (arstN),
        .lanes         (laneOut),
        .groupValid    (groupValid),
        .opCount       (opCount),
        .opIds         (opIds),
        .opRegD        (opRegD),
        .opRegA        (opRegA),
        .opRegB        (opRegB),
        .opOffsets     (opOffsets),
        .opBranchConds (opBranchConds),
        .illegalOp     (illegalOp),
        .halted        (halted)
    );

endmodule

`default_nettype wire

// File: hdl/fetchGroupSplitter.sv
`timescale 1ns/1ps
`default_nettype none

module fetchGroupSplitter import isaPkg::*, frontendPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  fetchValid,
    input  logic [FetchWidth-1:0] fetchWord,
    input  logic                  isUserRequest,
    input  logic                  wdInterruption,
    laneInIf.src                  lanes [LaneCount]
);

    logic                   trapReq;
    logic [OffsetWidth-1:0] trapOffset;
    logic [LaneCount-1:0]   laneValid;

    assign trapReq    = isUserRequest || wdInterruption;
    assign trapOffset = isUserRequest ? OffsetWidth'(UserTrapOffset)  // User request wins
                                      : OffsetWidth'(WatchdogTrapOffset);

    for (genvar i = 0; i < LaneCount; i++) begin : gLane
        assign laneValid[i] = lanes[i].valid;

        always_ff @(posedge clk or negedge arstN) begin
            if (!arstN) begin
                lanes[i].valid <= 1'b0;
                lanes[i].trap  <= 1'b0;
            end else begin
                // A trap occupies lane 0 alone and drops the fetch word
                lanes[i].valid <= (i == 0) ? (fetchValid || trapReq) : (fetchValid && !trapReq);
                lanes[i].trap  <= (i == 0) && trapReq;
            end
        end

        always_ff @(posedge clk) begin
            lanes[i].instr      <= fetchWord[InstrWidth*i +: InstrWidth]; // Lane 0 is oldest
            lanes[i].trapOffset <= trapOffset;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        (laneValid[0] && lanes[0].trap) |-> (laneValid[LaneCount-1:1] == '0))
        else $error("Younger lane valid beside a trap");

endmodule

`default_nettype wire

// File: hdl/frontendPkg.sv
`default_nettype none

package frontendPkg;

    localparam int LaneCount    = 4;  // Instructions per fetch group
    localparam int FetchWidth   = 64;
    localparam int LaneIdxWidth = 2;
    localparam int CountWidth   = 3;  // Holds 0 to LaneCount

    localparam int UserTrapOffset     = 3;
    localparam int WatchdogTrapOffset = 0;

    localparam int PipeLatency = 3;   // Splitter, decoder, retirer

endpackage

`default_nettype wire

// File: hdl/groupRetirer.sv
`timescale 1ns/1ps
`default_nettype none

module groupRetirer import isaPkg::*, frontendPkg::*; (
    input  logic                                   clk,
    input  logic                                   arstN,
    laneOutIf.dst                                  lanes [LaneCount],
    output logic                                   groupValid,
    output logic [CountWidth-1:0]                  opCount,
    output logic [LaneCount*IdWidth-1:0]           opIds,
    output logic [LaneCount*RegWidth-1:0]          opRegD,
    output logic [LaneCount*RegWidth-1:0]          opRegA,
    output logic [LaneCount*RegWidth-1:0]          opRegB,
    output logic [LaneCount*OffsetWidth-1:0]       opOffsets,
    output logic [LaneCount*BranchCondWidth-1:0]   opBranchConds,
    output logic                                   illegalOp,
    output logic                                   halted
);

    logic [LaneCount-1:0]                 laneValid;
    logic [LaneCount-1:0]                 laneIllegal;
    logic [LaneCount-1:0]                 laneHlt;
    logic [LaneCount-1:0]                 laneEnds;
    logic [LaneCount-1:0]                 keep;
    logic [LaneIdxWidth-1:0]              lastLane;
    logic                                 cut;
    logic                                 endIllegal;
    logic                                 endHlt;
    logic                                 accept;
    logic [LaneCount*IdWidth-1:0]         nextIds;
    logic [LaneCount*RegWidth-1:0]        nextRegD;
    logic [LaneCount*RegWidth-1:0]        nextRegA;
    logic [LaneCount*RegWidth-1:0]        nextRegB;
    logic [LaneCount*OffsetWidth-1:0]     nextOffsets;
    logic [LaneCount*BranchCondWidth-1:0] nextConds;

    assign accept = (|laneValid) && !halted; // Groups are dropped once halted

    for (genvar i = 0; i < LaneCount; i++) begin : gLane
        assign laneValid[i]   = lanes[i].valid;
        assign laneIllegal[i] = lanes[i].id inside {IdIllegal7a, IdIllegal7d, IdIllegal7e,
                                                     IdIllegal7f};
        assign laneHlt[i]     = lanes[i].id == IdHlt;
        assign laneEnds[i]    = laneIllegal[i] || laneHlt[i]
                             || (lanes[i].id inside {IdB, IdBx, IdNever, IdSwi});

        // Lanes after the group end read zero
        assign nextIds[IdWidth*i +: IdWidth]       = keep[i] ? lanes[i].id : '0;
        assign nextRegD[RegWidth*i +: RegWidth]    = keep[i] ? lanes[i].regD : '0;
        assign nextRegA[RegWidth*i +: RegWidth]    = keep[i] ? lanes[i].regA : '0;
        assign nextRegB[RegWidth*i +: RegWidth]    = keep[i] ? lanes[i].regB : '0;
        assign nextOffsets[OffsetWidth*i +: OffsetWidth] = keep[i] ? lanes[i].offset : '0;
        assign nextConds[BranchCondWidth*i +: BranchCondWidth] =
            keep[i] ? lanes[i].branchCond : '0;
    end

    always_comb begin
        cut        = 1'b0;
        lastLane   = '0;
        endIllegal = 1'b0;
        endHlt     = 1'b0;
        for (int i = 0; i < LaneCount; i++) begin
            keep[i] = accept && laneValid[i] && !cut; // Oldest first
            if (keep[i]) begin
                lastLane = LaneIdxWidth'(i);
                if (laneEnds[i]) begin
                    cut        = 1'b1;
                    endIllegal = laneIllegal[i];
                    endHlt     = laneHlt[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            groupValid <= 1'b0;
            opCount    <= '0;
            illegalOp  <= 1'b0;
            halted     <= 1'b0;
        end else begin
            groupValid <= accept;
            opCount    <= accept ? CountWidth'(lastLane) + CountWidth'(1) : '0;
            illegalOp  <= accept && endIllegal;   // One-cycle pulse
            halted     <= halted || (accept && endHlt); // Sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        opIds         <= nextIds;
        opRegD        <= nextRegD;
        opRegA        <= nextRegA;
        opRegB        <= nextRegB;
        opOffsets     <= nextOffsets;
        opBranchConds <= nextConds;
    end

    assert property (@(posedge clk) disable iff (!arstN) opCount <= CountWidth'(LaneCount))
        else $error("opCount above lane count");

    assert property (@(posedge clk) disable iff (!arstN) halted |=> !groupValid)
        else $error("Group retired while halted");

endmodule

`default_nettype wire

// File: hdl/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int InstrWidth      = 16;
    localparam int IdWidth         = 7;
    localparam int RegWidth        = 4;
    localparam int OffsetWidth     = 12;
    localparam int BranchCondWidth = 5;

    localparam logic [RegWidth-1:0] RegLr = 4'd12;
    localparam logic [RegWidth-1:0] RegSp = 4'd14;
    localparam logic [RegWidth-1:0] RegPc = 4'd15;

    localparam logic [IdWidth-1:0] IdBx        = 7'h26;
    localparam logic [IdWidth-1:0] IdSwi       = 7'h48; // Also used for traps
    localparam logic [IdWidth-1:0] IdB         = 7'h49;
    localparam logic [IdWidth-1:0] IdNop       = 7'h4a;
    localparam logic [IdWidth-1:0] IdHlt       = 7'h4b;
    localparam logic [IdWidth-1:0] IdNever     = 7'h4f; // Branch with condition 15
    localparam logic [IdWidth-1:0] IdReset     = 7'h64;
    localparam logic [IdWidth-1:0] IdIllegal7a = 7'h7a;
    localparam logic [IdWidth-1:0] IdIllegal7d = 7'h7d;
    localparam logic [IdWidth-1:0] IdIllegal7e = 7'h7e;
    localparam logic [IdWidth-1:0] IdIllegal7f = 7'h7f;

    localparam logic [BranchCondWidth-1:0] CondNone = 5'h1f;

    // One instruction word seen through its field layouts
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic       op;
            logic [4:0] imm5;
            logic [2:0] rA;
            logic [2:0] rD;
        } shiftForm;
        struct packed {
            logic [3:0] opcode;
            logic       op;
            logic [2:0] rD;
            logic [7:0] imm8;
        } immForm;
        struct packed {
            logic [3:0] opcode;
            logic [3:0] funct4;
            logic [1:0] funct2;
            logic [2:0] rB;
            logic [2:0] rD;
        } regForm;
        struct packed {
            logic [3:0] opcode;
            logic [3:0] cond;
            logic [7:0] imm8;
        } branchForm;
    } instrWord_u;

endpackage

`default_nettype wire

// File: hdl/laneDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module laneDecoder import isaPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    laneInIf.dst   laneIn,
    laneOutIf.src  laneOut
);

    instrWord_u                 ins;
    logic [IdWidth-1:0]         nextId;
    logic [RegWidth-1:0]        nextRegD;
    logic [RegWidth-1:0]        nextRegA;
    logic [RegWidth-1:0]        nextRegB;
    logic [OffsetWidth-1:0]     nextOffset;
    logic [BranchCondWidth-1:0] nextCond;

    assign ins = laneIn.instr;

    always_comb begin
        nextId     = '0;
        nextRegD   = '0;
        nextRegA   = '0;
        nextRegB   = '0;
        nextOffset = '0;
        nextCond   = CondNone;
        if (laneIn.trap) begin
            nextId     = IdSwi;              // System call replaces the group
            nextOffset = laneIn.trapOffset;
        end else begin
            case (ins.shiftForm.opcode)
                4'd0, 4'd6, 4'd7, 4'd8: begin // Shift and load/store immediate
                    nextRegD   = RegWidth'(ins.shiftForm.rD);
                    nextRegA   = RegWidth'(ins.shiftForm.rA);
                    nextOffset = OffsetWidth'(ins.shiftForm.imm5);
                    if (ins.shiftForm.opcode == 4'd0)
                        nextId = ins.shiftForm.op ? 7'h02 : 7'h01;
                    else
                        nextId = 7'h30 + IdWidth'({ins.shiftForm.opcode - 4'd6, ins.shiftForm.op});
                end
                4'd1: begin
                    nextRegD = RegWidth'(ins.shiftForm.rD);
                    nextRegA = RegWidth'(ins.shiftForm.rA);
                    if (!ins.shiftForm.op) begin
                        nextId     = 7'h03;
                        nextOffset = OffsetWidth'(ins.shiftForm.imm5);
                    end else begin
                        nextId = 7'h04 + IdWidth'(ins.shiftForm.imm5[4:3]);
                        if (ins.shiftForm.imm5[4])
                            nextOffset = OffsetWidth'(ins.shiftForm.imm5[2:0]); // 3-bit immediate
                        else
                            nextRegB = RegWidth'(ins.shiftForm.imm5[2:0]);
                    end
                end
                4'd2, 4'd3: begin
                    nextId     = 7'h08 + IdWidth'({ins.immForm.opcode[0], ins.immForm.op});
                    nextRegD   = RegWidth'(ins.immForm.rD);
                    nextRegA   = RegWidth'(ins.immForm.rD);
                    nextOffset = OffsetWidth'(ins.immForm.imm8);
                end
                4'd4: begin
                    if (ins.immForm.op) begin
                        nextId     = 7'h27;
                        nextRegD   = RegWidth'(ins.immForm.rD);
                        nextRegA   = RegPc;
                        nextRegB   = RegWidth'(ins.immForm.rD);
                        nextOffset = OffsetWidth'(ins.immForm.imm8);
                    end else begin
                        nextRegD = RegWidth'(ins.regForm.rD);
                        nextRegA = RegWidth'(ins.regForm.rD);
                        nextRegB = RegWidth'(ins.regForm.rB);
                        case (ins.regForm.funct4)
                            4'd0, 4'd1, 4'd2, 4'd3:
                                nextId = 7'h0c + IdWidth'({ins.regForm.funct4[1:0], ins.regForm.funct2});
                            4'd4, 4'd5, 4'd6: begin // High register forms
                                nextRegB[3] = ins.regForm.funct2[0]
                                    && !(ins.regForm.funct4 == 4'd5 && ins.regForm.funct2 == 2'd3);
                                nextRegD[3] = ins.regForm.funct2[1];
                                nextRegA[3] = ins.regForm.funct2[1];
                                if (ins.regForm.funct4 == 4'd6)
                                    nextId = 7'h22 + IdWidth'(ins.regForm.funct2);
                                else if (ins.regForm.funct2 == 2'd0)
                                    nextId = 7'h0c;
                                else
                                    nextId = (ins.regForm.funct4 == 4'd4 ? 7'h1b : 7'h1e)
                                           + IdWidth'(ins.regForm.funct2);
                            end
                            4'd7: begin
                                nextCond = {1'b0, ins.regForm.funct2, ins.regForm.rB[2:1]};
                                nextId   = (nextCond == 5'hf) ? IdNever : IdBx;
                                nextRegA = RegPc;
                                nextRegB = RegWidth'(ins.regForm.rD);
                                nextRegD = RegLr;
                            end
                            default: nextId = IdIllegal7d;
                        endcase
                    end
                end
                4'd5: begin
                    nextId   = 7'h28 + IdWidth'({ins.shiftForm.op, ins.shiftForm.imm5[4:3]});
                    nextRegD = RegWidth'(ins.shiftForm.rD);
                    nextRegA = RegWidth'(ins.shiftForm.rA);
                    nextRegB = RegWidth'(ins.shiftForm.imm5[2:0]);
                end
                4'd9, 4'd10: begin // Stack and PC relative
                    nextRegD   = RegWidth'(ins.immForm.rD);
                    nextOffset = OffsetWidth'(ins.immForm.imm8);
                    if (ins.immForm.opcode == 4'd9) begin
                        nextId   = ins.immForm.op ? 7'h37 : 7'h36;
                        nextRegA = RegSp;
                    end else begin
                        nextId   = ins.immForm.op ? 7'h39 : 7'h38;
                        nextRegA = ins.immForm.op ? RegSp : RegPc;
                    end
                end
                4'd11: begin
                    case (ins.regForm.funct4)
                        4'd0: begin
                            if (ins.regForm.funct2 == 2'd1) begin
                                nextId   = 7'h4c;
                                nextRegA = {ins.regForm.rB[0], ins.regForm.rD};
                            end else begin
                                nextId   = 7'h3a;
                                nextRegD = {ins.regForm.rB[0], ins.regForm.rD};
                            end
                        end
                        4'd2, 4'd10: begin
                            nextId   = (ins.regForm.funct4 == 4'd2 ? 7'h3b : 7'h3f)
                                     + IdWidth'(ins.regForm.funct2);
                            nextRegD = RegWidth'(ins.regForm.rD);
                            nextRegB = RegWidth'(ins.regForm.rB);
                        end
                        4'd4, 4'd13: begin
                            if (ins.regForm.funct2[1]) begin // Multiple push or pop
                                nextId     = (ins.regForm.funct4 == 4'd4) ? 7'h4d : 7'h4e;
                                nextOffset = OffsetWidth'({ins.regForm.funct2[0], ins.regForm.rB,
                                                           ins.regForm.rD});
                                nextRegA   = RegSp;
                            end else begin
                                nextId   = (ins.regForm.funct4 == 4'd4) ? 7'h43 : 7'h44;
                                nextRegD = RegWidth'(ins.regForm.rD);
                            end
                        end
                        4'd14: begin // Output, pause, input
                            nextId   = (ins.regForm.funct2 == 2'd3) ? IdIllegal7a
                                     : 7'h45 + IdWidth'(ins.regForm.funct2);
                            nextRegD = ins.regForm.funct2[0] ? '0 : RegWidth'(ins.regForm.rD);
                        end
                        default: nextId = IdIllegal7a;
                    endcase
                end
                4'd12: begin
                    nextId     = IdSwi;
                    nextOffset = OffsetWidth'(ins.branchForm.imm8);
                end
                4'd13: begin
                    nextCond   = BranchCondWidth'(ins.branchForm.cond);
                    nextId     = (ins.branchForm.cond == 4'hf) ? IdNever : IdB;
                    nextOffset = OffsetWidth'(ins.branchForm.imm8);
                    nextRegA   = RegPc;
                    nextRegD   = RegLr;
                end
                4'd14: nextId = ins.immForm.op ? IdHlt : IdNop;
                default: nextId = (ins == 16'hffff) ? IdReset : IdIllegal7f;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            laneOut.valid <= 1'b0;
        else
            laneOut.valid <= laneIn.valid;
    end

    always_ff @(posedge clk) begin
        laneOut.id         <= nextId;
        laneOut.regD       <= nextRegD;
        laneOut.regA       <= nextRegA;
        laneOut.regB       <= nextRegB;
        laneOut.offset     <= nextOffset;
        laneOut.branchCond <= nextCond;
    end

    assert property (@(posedge clk) disable iff (!arstN) laneOut.valid |-> !$isunknown(laneOut.id))
        else $error("Unknown operation ID on a valid lane");

endmodule

`default_nettype wire

// File: hdl/laneIfs.sv
`timescale 1ns/1ps
`default_nettype none

// Splitter to decoder, one per lane
interface laneInIf import isaPkg::*; ();
    logic                   valid;
    instrWord_u             instr;
    logic                   trap;
    logic [OffsetWidth-1:0] trapOffset;

    modport src (output valid, instr, trap, trapOffset);
    modport dst (input valid, instr, trap, trapOffset);
endinterface

// Decoder to retirer, one per lane
interface laneOutIf import isaPkg::*; ();
    logic                       valid;
    logic [IdWidth-1:0]         id;
    logic [RegWidth-1:0]        regD;
    logic [RegWidth-1:0]        regA;
    logic [RegWidth-1:0]        regB;
    logic [OffsetWidth-1:0]     offset;
    logic [BranchCondWidth-1:0] branchCond;

    modport src (output valid, id, regD, regA, regB, offset, branchCond);
    modport dst (input valid, id, regD, regA, regB, offset, branchCond);
endinterface

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile and run the decode front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tbDecodeFrontend \
    -o simDecodeFrontend > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Compile failed, see build.log"
    exit 1
fi

./obj_dir/simDecodeFrontend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
fi
echo "No pass message found in sim.log"
exit 1

// File: sim/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
    logic [6:0]  id;
    logic [3:0]  regD;
    logic [3:0]  regA;
    logic [3:0]  regB;
    logic [11:0] offset;
    logic [4:0]  cond;
} laneExp_t;

// Same bit order as the flat DUT outputs
typedef struct packed {
    logic        illegal;
    logic [2:0]  count;
    logic [27:0] ids;
    logic [15:0] regD;
    logic [15:0] regA;
    logic [15:0] regB;
    logic [47:0] offsets;
    logic [19:0] conds;
} groupExp_t;

// Covers the word classes the stimulus produces
function automatic laneExp_t decodeWord(input logic [15:0] w);
    laneExp_t e;
    e = '0;
    e.cond = 5'h1f;                                   // No branch
    case (w[15:12])
        4'd0: begin
            e.id     = w[11] ? 7'h02 : 7'h01;
            e.regD   = {1'b0, w[2:0]};
            e.regA   = {1'b0, w[5:3]};
            e.offset = {7'd0, w[10:6]};               // imm5
        end
        4'd2: begin
            e.id     = w[11] ? 7'h09 : 7'h08;
            e.regD   = {1'b0, w[10:8]};
            e.regA   = {1'b0, w[10:8]};               // Shared with RegD
            e.offset = {4'd0, w[7:0]};
        end
        4'd5: begin
            e.id   = 7'h28 + {4'd0, w[11:9]};
            e.regD = {1'b0, w[2:0]};
            e.regA = {1'b0, w[5:3]};
            e.regB = {1'b0, w[8:6]};
        end
        4'd11: e.id = 7'h7a;                          // Only illegal forms are sent
        4'd13: begin
            e.cond   = {1'b0, w[11:8]};
            e.id     = (w[11:8] == 4'hf) ? 7'h4f : 7'h49;
            e.offset = {4'd0, w[7:0]};
            e.regA   = 4'd15;                         // PC
            e.regD   = 4'd12;                         // LR
        end
        4'd14: e.id = w[11] ? 7'h4b : 7'h4a;
        default: e.id = (w == 16'hffff) ? 7'h64 : 7'h7f;
    endcase
    return e;
endfunction

function automatic logic endsGroup(input logic [6:0] id);
    return id inside {7'h26, 7'h48, 7'h49, 7'h4b, 7'h4f, 7'h7a, 7'h7d, 7'h7e, 7'h7f};
endfunction

function automatic groupExp_t buildGroup(input logic [63:0] word);
    groupExp_t g;
    laneExp_t  e;
    logic      done;
    g    = '0;
    done = 1'b0;
    for (int i = 0; i < 4; i++) begin
        if (!done) begin                              // Oldest lane first
            e = decodeWord(word[16*i +: 16]);
            g.count              = 3'(i + 1);
            g.ids[7*i +: 7]      = e.id;
            g.regD[4*i +: 4]     = e.regD;
            g.regA[4*i +: 4]     = e.regA;
            g.regB[4*i +: 4]     = e.regB;
            g.offsets[12*i +: 12] = e.offset;
            g.conds[5*i +: 5]    = e.cond;
            if (endsGroup(e.id)) begin
                done      = 1'b1;
                g.illegal = (e.id >= 7'h7a);
            end
        end
    end
    return g;
endfunction

function automatic groupExp_t trapGroup(input logic userReq);
    groupExp_t g;
    g = '0;
    g.count         = 3'd1;
    g.ids[6:0]      = 7'h48;
    g.offsets[11:0] = userReq ? 12'd3 : 12'd0;        // User request wins
    g.conds[4:0]    = 5'h1f;
    return g;
endfunction

function automatic logic endsOnHlt(input groupExp_t g);
    return g.ids[7*(g.count-1) +: 7] == 7'h4b;
endfunction

`endif

// File: sim/tbDecodeFrontend.sv
`timescale 1ns/1ps
`default_nettype none

module tbDecodeFrontend import isaPkg::*, frontendPkg::*; ();

`include "decodeModel.svh"

    logic                                 clk;
    logic                                 arstN;
    logic                                 fetchValid;
    logic [FetchWidth-1:0]                fetchWord;
    logic                                 isUserRequest;
    logic                                 wdInterruption;
    logic                                 groupValid;
    logic [CountWidth-1:0]                opCount;
    logic [LaneCount*IdWidth-1:0]         opIds;
    logic [LaneCount*RegWidth-1:0]        opRegD;
    logic [LaneCount*RegWidth-1:0]        opRegA;
    logic [LaneCount*RegWidth-1:0]        opRegB;
    logic [LaneCount*OffsetWidth-1:0]     opOffsets;
    logic [LaneCount*BranchCondWidth-1:0] opBranchConds;
    logic                                 illegalOp;
    logic                                 halted;

    groupExp_t   expQ [$];
    int          dueQ [$];
    groupExp_t   expCur;
    groupExp_t   got;
    logic        haveExp     = 1'b0;
    logic        onTime      = 1'b0;
    logic        missedGroup = 1'b0;
    logic        haltExp     = 1'b0;
    logic        dropAll     = 1'b0;
    logic        timedOut    = 1'b0;
    int          cycle       = 0;
    int          errorCount  = 0;
    int          testCount   = 0;
    int          failedTests = 0;
    int          errs;
    int          lane;
    integer      seed;
    logic [63:0] word;

    decodeFrontend i_dut (.*);

    assign got = {illegalOp, opCount, opIds, opRegD, opRegA, opRegB, opOffsets, opBranchConds};

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // Pops the expectation for each group, flags groups that never come
    always @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            haveExp     = 1'b0;
            onTime      = 1'b0;
            missedGroup = 1'b0;
            haltExp     = 1'b0;
        end else begin
            haveExp     = 1'b0;
            missedGroup = 1'b0;
            if (groupValid && expQ.size() > 0) begin
                expCur  = expQ.pop_front();
                onTime  = (dueQ.pop_front() == cycle);
                haveExp = 1'b1;
                haltExp = haltExp || endsOnHlt(expCur);
            end else if (!groupValid && dueQ.size() > 0 && dueQ[0] <= cycle) begin
                expQ.delete(0);
                dueQ.delete(0);
                missedGroup = 1'b1;
            end
        end
    end

    groupPresentCheck: assert property (@(posedge clk) disable iff (!arstN)
        groupValid |-> haveExp)
        else begin
            errorCount++;
            $display("A group came out at %0t although none was expected", $time);
        end

    groupTimingCheck: assert property (@(posedge clk) disable iff (!arstN)
        (groupValid && haveExp) |-> onTime)
        else begin
            errorCount++;
            $display("[ERROR] %0t group not %0d cycles after its fetch", $time, PipeLatency);
        end

    groupValueCheck: assert property (@(posedge clk) disable iff (!arstN)
        (groupValid && haveExp) |-> (got == expCur))
        else begin
            errorCount++;
            $display("[ERROR] %0t group mismatch: got %h, expected %h", $time, got, expCur);
        end

    missedCheck: assert property (@(posedge clk) disable iff (!arstN) !missedGroup)
        else begin
            errorCount++;
            $display("An expected group did not come out in time");
        end

    strayIllegalCheck: assert property (@(posedge clk) disable iff (!arstN)
        !groupValid |-> !illegalOp)
        else begin
            errorCount++;
            $display("[ERROR] %0t illegalOp without a group", $time);
        end

    haltCheck: assert property (@(posedge clk) disable iff (!arstN) halted == haltExp)
        else begin
            errorCount++;
            $display("[ERROR] %0t halted is %b, expected %b", $time, halted, haltExp);
        end

    // Non-control words only, NOP keeps the group going
    function automatic logic [15:0] randWord();
        logic [15:0] w;
        int          pick;
        w    = 16'($random(seed));
        pick = {$random(seed)} % 4;
        case (pick)
            0: w[15:12] = 4'd0;
            1: w[15:12] = 4'd2;
            2: w[15:12] = 4'd5;
            default: begin
                w[15:12] = 4'd14;
                w[11]    = 1'b0;
            end
        endcase
        return w;
    endfunction

    function automatic logic [63:0] randomGroup();
        return {randWord(), randWord(), randWord(), randWord()};
    endfunction

    task automatic sendGroup(input logic [63:0] w, input logic user, input logic wd);
        groupExp_t g;
        @(negedge clk);
        fetchValid     = 1'b1;
        fetchWord      = w;
        isUserRequest  = user;
        wdInterruption = wd;
        g = (user || wd) ? trapGroup(user) : buildGroup(w);
        if (!dropAll) begin                           // Dropped once halted
            expQ.push_back(g);
            dueQ.push_back(cycle + PipeLatency);
            dropAll = endsOnHlt(g);
        end
    endtask

    task automatic idle();
        @(negedge clk);
        fetchValid     = 1'b0;
        isUserRequest  = 1'b0;
        wdInterruption = 1'b0;
    endtask

    task automatic waitDrain();
        int t;
        for (t = 0; t < 8 * PipeLatency && expQ.size() > 0; t++)
            @(negedge clk);
        if (expQ.size() > 0) begin
            $display("Timeout while waiting for %0d expected group(s)", expQ.size());
            timedOut = 1'b1;
            errorCount++;
            expQ.delete();
            dueQ.delete();
        end
        @(negedge clk);                               // Let the last check fire
    endtask

    task automatic endTest(input string name, input int errsBefore);
        testCount++;
        if (errorCount == errsBefore) begin
            $display("Test %s: ok", name);
        end else begin
            failedTests++;
            $display("Test %s: %0d error(s)", name, errorCount - errsBefore);
        end
    endtask

    task automatic applyReset();
        arstN   = 1'b0;
        dropAll = 1'b0;
        repeat (5) @(negedge clk);
        arstN = 1'b1;
    endtask

    initial begin
        seed           = 32'h0949_2c79;
        fetchValid     = 1'b0;
        fetchWord      = '0;
        isUserRequest  = 1'b0;
        wdInterruption = 1'b0;
        applyReset();

        errs = errorCount;
        repeat (8) sendGroup(randomGroup(), 1'b0, 1'b0);
        idle();
        waitDrain();
        endTest("lane decode", errs);

        errs = errorCount;
        for (int k = 0; k < 6; k++) begin
            word = randomGroup();
            lane = {$random(seed)} % LaneCount;
            word[16*lane +: 16] = {4'hd, (k == 0) ? 4'hf : 4'($random(seed)), 8'($random(seed))};
            sendGroup(word, 1'b0, 1'b0);
        end
        idle();
        waitDrain();
        endTest("group truncation", errs);

        errs = errorCount;
        sendGroup(randomGroup(), 1'b1, 1'b0);
        sendGroup(randomGroup(), 1'b0, 1'b1);
        sendGroup(randomGroup(), 1'b1, 1'b1);
        idle();
        waitDrain();
        endTest("traps", errs);

        errs = errorCount;
        word = randomGroup();
        word[15:0]  = 16'hffff;
        word[47:32] = {8'hb1, 8'($random(seed))};     // Undefined opcode-11 form
        sendGroup(word, 1'b0, 1'b0);
        sendGroup({randWord(), randWord(), 16'hf123, randWord()}, 1'b0, 1'b0);
        sendGroup({randWord(), 16'hbec0, randWord(), randWord()}, 1'b0, 1'b0);
        sendGroup({4{16'hffff}}, 1'b0, 1'b0);
        idle();
        waitDrain();
        endTest("illegal and reset words", errs);

        errs = errorCount;
        repeat (6) sendGroup(randomGroup(), 1'b0, 1'b0);
        word = randomGroup();
        lane = {$random(seed)} % LaneCount;
        word[16*lane +: 16] = {5'b11101, 11'($random(seed))}; // HLT
        sendGroup(word, 1'b0, 1'b0);
        repeat (3) sendGroup(randomGroup(), 1'b0, 1'b0);
        idle();
        waitDrain();
        repeat (2 * PipeLatency) @(negedge clk);      // Window for stray groups
        applyReset();
        sendGroup(randomGroup(), 1'b0, 1'b0);
        idle();
        waitDrain();
        endTest("pipelining and halt", errs);

        $display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failedTests, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
